//--- hw/fetch_buf_pkg.sv
// shared codes and lane tables; size code 0 (4x4) is reserved and maps to the identity table
`default_nettype none

package fetch_buf_pkg;

  // ------------------------------------------------------------------------
  // bank geometry
  // ------------------------------------------------------------------------
  localparam int NUM_BANKS   = 4;
  localparam int LANE_PIX    = 8;
  // 6 regions of 32 words: luma 0..3, chroma u 4, chroma v 5
  localparam int BANK_DEPTH  = 192;
  localparam int BANK_ADDR_W = 8;

  typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

  typedef enum logic [1:0] {
    SIZE_04 = 2'd0,
    SIZE_08 = 2'd1,
    SIZE_16 = 2'd2,
    SIZE_32 = 2'd3
  } blk_size_e;

  typedef enum logic [1:0] {
    PLANE_Y = 2'd0,
    PLANE_U = 2'd2,
    PLANE_V = 2'd3
  } plane_e;

  // {size code, rotation code}
  typedef logic [3:0] perm_sel_t;

  // ------------------------------------------------------------------------
  // lane permutation
  // ------------------------------------------------------------------------
  // bank feeding output lane, lane 0 is the top slice of the row
  function automatic logic [1:0] lane_bank(perm_sel_t sel, logic [1:0] lane);
    logic [7:0] row;
    case (sel)
      4'd4:    row = 8'b00_01_10_11;
      4'd5:    row = 8'b10_11_00_01;
      4'd6:    row = 8'b01_10_11_00;
      4'd7:    row = 8'b11_00_01_10;
      4'd8:    row = 8'b00_10_01_11;
      4'd9:    row = 8'b10_00_11_01;
      4'd10:   row = 8'b01_11_10_00;
      4'd11:   row = 8'b11_01_00_10;
      4'd12:   row = 8'b00_10_01_11;
      4'd13:   row = 8'b01_11_10_00;
      4'd14:   row = 8'b10_00_11_01;
      4'd15:   row = 8'b11_01_00_10;
      default: row = 8'b00_01_10_11;
    endcase
    return row[(3 - int'(lane)) * 2 +: 2];
  endfunction

endpackage

`default_nettype wire

//--- hw/blk_addr_map.sv
// combinational block-to-bank address map; 4x4 blocks are unsupported and x/y bit 0 is ignored
`timescale 1ns/1ps
`default_nettype none

module blk_addr_map (
  input  wire                                                    valid_i,
  input  fetch_buf_pkg::plane_e                                  plane_i,
  input  fetch_buf_pkg::blk_size_e                               size_i,
  input  wire [3:0]                                              x_i,
  input  wire [3:0]                                              y_i,
  input  wire [4:0]                                              idx_i,
  output fetch_buf_pkg::bank_addr_t [fetch_buf_pkg::NUM_BANKS-1:0] bank_addr_o,
  output fetch_buf_pkg::perm_sel_t                               perm_sel_o
);

  import fetch_buf_pkg::*;

  logic [2:0]                  region;
  logic [2:0]                  row;
  logic [1:0]                  rot;
  logic [NUM_BANKS-1:0][1:0]   col;

  // ------------------------------------------------------------------------
  // region field
  // ------------------------------------------------------------------------
  always_comb begin
    if (plane_i == PLANE_Y) begin
      region = {1'b0, y_i[3], x_i[3]};
    end else begin
      // chroma: u and v sit in regions 4 and 5
      region = {2'b10, plane_i[0]};
    end
  end

  // ------------------------------------------------------------------------
  // row field and rotation code
  // ------------------------------------------------------------------------
  always_comb begin
    row = 3'd0;
    rot = 2'd0;
    case (size_i)
      SIZE_08: begin
        row = {y_i[2:1], idx_i[2]};
        rot = x_i[2:1];
      end
      SIZE_16: begin
        row = {y_i[2], idx_i[3:2]};
        rot = {x_i[2], idx_i[1]};
      end
      SIZE_32: begin
        row = idx_i[4:2];
        rot = idx_i[1:0];
      end
      default: begin
        row = 3'd0;
        rot = 2'd0;
      end
    endcase
  end

  assign perm_sel_o = {size_i, rot};

  // ------------------------------------------------------------------------
  // column field
  // ------------------------------------------------------------------------
  // inverse of lane_bank: column of bank b is the lane it serves
  always_comb begin
    col = '0;
    for (int j = 0; j < NUM_BANKS; j++) begin
      col[lane_bank(perm_sel_o, 2'(j))] = 2'(j);
    end
  end

  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_addr_o[b] = {region, row, col[b]};
    end
  end

  // the requester must never present a 4x4 block
  always_comb begin
    if (valid_i) begin
      assert (size_i != SIZE_04)
        else $error("blk_addr_map: 4x4 block requested");
    end
  end

endmodule

`default_nettype wire

//--- hw/bank_ram.sv
// single-port bank, whole-word writes only; read data appears one cycle after rd_en_i
`timescale 1ns/1ps
`default_nettype none

module bank_ram #(
  parameter int PIX_W = 8
) (
  input  wire                                         clk,
  input  wire                                         rstn,
  input  fetch_buf_pkg::bank_addr_t                   addr_i,
  input  wire                                         wr_en_i,
  input  wire [fetch_buf_pkg::LANE_PIX*PIX_W-1:0]     wr_dat_i,
  input  wire                                         rd_en_i,
  output logic [fetch_buf_pkg::LANE_PIX*PIX_W-1:0]    rd_dat_o
);

  import fetch_buf_pkg::*;

  localparam int WORD_W = LANE_PIX * PIX_W;

  logic [WORD_W-1:0] mem [BANK_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[addr_i] <= wr_dat_i;
    end
    if (rd_en_i) begin
      rd_dat_o <= mem[addr_i];
    end
  end

  // one port only, the array must arbitrate
  assert property (@(posedge clk) disable iff (!rstn) !(wr_en_i && rd_en_i))
    else $error("bank_ram: write and read in the same cycle");

  assert property (@(posedge clk) disable iff (!rstn)
                   (wr_en_i || rd_en_i) |-> (int'(addr_i) < BANK_DEPTH))
    else $error("bank_ram: address out of range");

endmodule

`default_nettype wire

//--- hw/bank_array.sv
// four banks with read priority; wr_en_i must already be low whenever rd_en_i is high
`timescale 1ns/1ps
`default_nettype none

module bank_array #(
  parameter int PIX_W = 8
) (
  input  wire                                                      clk,
  input  wire                                                      rstn,
  input  wire                                                      wr_en_i,
  input  fetch_buf_pkg::bank_addr_t [fetch_buf_pkg::NUM_BANKS-1:0] wr_addr_i,
  input  fetch_buf_pkg::perm_sel_t                                 wr_perm_i,
  input  wire [fetch_buf_pkg::NUM_BANKS*fetch_buf_pkg::LANE_PIX*PIX_W-1:0] wr_dat_i,
  input  wire                                                      rd_en_i,
  input  fetch_buf_pkg::bank_addr_t [fetch_buf_pkg::NUM_BANKS-1:0] rd_addr_i,
  input  fetch_buf_pkg::perm_sel_t                                 rd_perm_i,
  output logic                                                     rd_valid_o,
  output logic [fetch_buf_pkg::NUM_BANKS*fetch_buf_pkg::LANE_PIX*PIX_W-1:0] rd_dat_o
);

  import fetch_buf_pkg::*;

  localparam int WORD_W = LANE_PIX * PIX_W;

  bank_addr_t [NUM_BANKS-1:0]              bank_addr;
  logic       [NUM_BANKS-1:0][WORD_W-1:0]  bank_wdat;
  logic       [NUM_BANKS-1:0][WORD_W-1:0]  bank_rdat;
  perm_sel_t                               rd_perm_q;
  logic                                    rd_valid_q;

  // ------------------------------------------------------------------------
  // address select and write scatter
  // ------------------------------------------------------------------------
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_addr[b] = rd_en_i ? rd_addr_i[b] : wr_addr_i[b];
    end
  end

  // row lane j goes to the bank the table names for it
  always_comb begin
    bank_wdat = '0;
    for (int j = 0; j < NUM_BANKS; j++) begin
      bank_wdat[lane_bank(wr_perm_i, 2'(j))] = wr_dat_i[(NUM_BANKS-1-j)*WORD_W +: WORD_W];
    end
  end

  // ------------------------------------------------------------------------
  // banks
  // ------------------------------------------------------------------------
  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    bank_ram #(
      .PIX_W    (PIX_W)
    ) u_bank (
      .clk      (clk),
      .rstn     (rstn),
      .addr_i   (bank_addr[b]),
      .wr_en_i  (wr_en_i),
      .wr_dat_i (bank_wdat[b]),
      .rd_en_i  (rd_en_i),
      .rd_dat_o (bank_rdat[b])
    );
  end

  // ------------------------------------------------------------------------
  // read gather
  // ------------------------------------------------------------------------
  // selector follows the read into the data cycle
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_valid_q <= 1'b0;
      rd_perm_q  <= '0;
    end else begin
      rd_valid_q <= rd_en_i;
      if (rd_en_i) begin
        rd_perm_q <= rd_perm_i;
      end
    end
  end

  always_comb begin
    for (int j = 0; j < NUM_BANKS; j++) begin
      rd_dat_o[(NUM_BANKS-1-j)*WORD_W +: WORD_W] = bank_rdat[lane_bank(rd_perm_q, 2'(j))];
    end
  end

  assign rd_valid_o = rd_valid_q;

  // data returned one cycle later must carry a supported block size
  assert property (@(posedge clk) disable iff (!rstn)
                   rd_en_i |=> (rd_perm_q[3:2] != SIZE_04))
    else $error("bank_array: read gathered with an unsupported size");

endmodule

`default_nettype wire

//--- hw/fetch_buf_top.sv
// pixel fetch buffer; reads always win, so a write waits while rd_valid_i is high
`timescale 1ns/1ps
`default_nettype none

module fetch_buf_top #(
  parameter int PIX_W = 8
) (
  input  wire                                                               clk,
  input  wire                                                               rstn,
  // write side
  input  wire                                                               wr_valid_i,
  output logic                                                              wr_ready_o,
  input  fetch_buf_pkg::plane_e                                             wr_plane_i,
  input  fetch_buf_pkg::blk_size_e                                          wr_size_i,
  input  wire [3:0]                                                         wr_x_i,
  input  wire [3:0]                                                         wr_y_i,
  input  wire [4:0]                                                         wr_idx_i,
  input  wire [fetch_buf_pkg::NUM_BANKS*fetch_buf_pkg::LANE_PIX*PIX_W-1:0]  wr_dat_i,
  // read side
  input  wire                                                               rd_valid_i,
  input  fetch_buf_pkg::plane_e                                             rd_plane_i,
  input  fetch_buf_pkg::blk_size_e                                          rd_size_i,
  input  wire [3:0]                                                         rd_x_i,
  input  wire [3:0]                                                         rd_y_i,
  input  wire [4:0]                                                         rd_idx_i,
  output logic                                                              rd_valid_o,
  output logic [fetch_buf_pkg::NUM_BANKS*fetch_buf_pkg::LANE_PIX*PIX_W-1:0] rd_dat_o
);

  import fetch_buf_pkg::*;

  bank_addr_t [NUM_BANKS-1:0] wr_addr;
  bank_addr_t [NUM_BANKS-1:0] rd_addr;
  perm_sel_t                  wr_perm;
  perm_sel_t                  rd_perm;
  logic                       wr_en;

  // banks are single port, a read blocks the write
  assign wr_ready_o = ~rd_valid_i;
  assign wr_en      = wr_valid_i & wr_ready_o;

  blk_addr_map u_wr_map (
    .valid_i     (wr_valid_i),
    .plane_i     (wr_plane_i),
    .size_i      (wr_size_i),
    .x_i         (wr_x_i),
    .y_i         (wr_y_i),
    .idx_i       (wr_idx_i),
    .bank_addr_o (wr_addr),
    .perm_sel_o  (wr_perm)
  );

  blk_addr_map u_rd_map (
    .valid_i     (rd_valid_i),
    .plane_i     (rd_plane_i),
    .size_i      (rd_size_i),
    .x_i         (rd_x_i),
    .y_i         (rd_y_i),
    .idx_i       (rd_idx_i),
    .bank_addr_o (rd_addr),
    .perm_sel_o  (rd_perm)
  );

  bank_array #(
    .PIX_W      (PIX_W)
  ) u_bank_array (
    .clk        (clk),
    .rstn       (rstn),
    .wr_en_i    (wr_en),
    .wr_addr_i  (wr_addr),
    .wr_perm_i  (wr_perm),
    .wr_dat_i   (wr_dat_i),
    .rd_en_i    (rd_valid_i),
    .rd_addr_i  (rd_addr),
    .rd_perm_i  (rd_perm),
    .rd_valid_o (rd_valid_o),
    .rd_dat_o   (rd_dat_o)
  );

endmodule

`default_nettype wire

//--- bench/tb_fetch_buf.sv
// x and y are in 4x4 units; only lanes of rows written earlier in the run are compared
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_buf;

  import fetch_buf_pkg::*;

  localparam int PIX_W      = 8;
  localparam int WORD_W     = LANE_PIX * PIX_W;
  localparam int ROW_W      = NUM_BANKS * WORD_W;
  localparam int WAIT_LIMIT = 50;

  // bank for lanes 0..3, one group of four per rotation code
  localparam int T8[16]  = '{0, 1, 2, 3,  2, 3, 0, 1,  1, 2, 3, 0,  3, 0, 1, 2};
  localparam int T16[16] = '{0, 2, 1, 3,  2, 0, 3, 1,  1, 3, 2, 0,  3, 1, 0, 2};
  localparam int T32[16] = '{0, 2, 1, 3,  1, 3, 2, 0,  2, 0, 3, 1,  3, 1, 0, 2};

  logic             clk;
  logic             rstn;
  logic             wr_valid;
  logic             wr_ready;
  plane_e           wr_plane;
  blk_size_e        wr_size;
  logic [3:0]       wr_x, wr_y;
  logic [4:0]       wr_idx;
  logic [ROW_W-1:0] wr_dat;
  logic             rd_valid;
  plane_e           rd_plane;
  blk_size_e        rd_size;
  logic [3:0]       rd_x, rd_y;
  logic [4:0]       rd_idx;
  logic             out_valid;
  logic [ROW_W-1:0] out_dat;

  // inputs for the next rising edge
  logic             n_wr_valid;
  plane_e           n_wr_plane;
  blk_size_e        n_wr_size;
  logic [3:0]       n_wr_x, n_wr_y;
  logic [4:0]       n_wr_idx;
  logic [ROW_W-1:0] n_wr_dat;
  logic             n_rd_valid;
  plane_e           n_rd_plane;
  blk_size_e        n_rd_size;
  logic [3:0]       n_rd_x, n_rd_y;
  logic [4:0]       n_rd_idx;

  logic [WORD_W-1:0] model_mem [NUM_BANKS][BANK_DEPTH];
  bit                model_set [NUM_BANKS][BANK_DEPTH];
  logic [ROW_W-1:0]  exp_dat;
  logic [3:0]        exp_mask;
  logic              exp_valid;
  logic              wr_taken;
  int                held_cnt;
  int                fail_cnt;
  logic [31:0]       lfsr_state;

  fetch_buf_top #(
    .PIX_W      (PIX_W)
  ) fetch_buf_top_inst (
    .clk        (clk),
    .rstn       (rstn),
    .wr_valid_i (wr_valid),
    .wr_ready_o (wr_ready),
    .wr_plane_i (wr_plane),
    .wr_size_i  (wr_size),
    .wr_x_i     (wr_x),
    .wr_y_i     (wr_y),
    .wr_idx_i   (wr_idx),
    .wr_dat_i   (wr_dat),
    .rd_valid_i (rd_valid),
    .rd_plane_i (rd_plane),
    .rd_size_i  (rd_size),
    .rd_x_i     (rd_x),
    .rd_y_i     (rd_y),
    .rd_idx_i   (rd_idx),
    .rd_valid_o (out_valid),
    .rd_dat_o   (out_dat)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // ------------------------------------------------------------------------
  // random source
  // ------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one step per bit taken
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return r;
  endfunction

  function automatic logic [ROW_W-1:0] rand_row();
    logic [ROW_W-1:0] r;
    for (int k = 0; k < ROW_W / 64; k++) begin
      r[k*64 +: 64] = rand_bits(64);
    end
    return r;
  endfunction

  function automatic blk_size_e rand_size();
    logic [1:0] s;
    s = 2'(rand_bits(2));
    // code 0 would be 4x4
    return (s == 2'd0) ? SIZE_32 : blk_size_e'(s);
  endfunction

  function automatic plane_e rand_plane();
    logic [1:0] p;
    p = 2'(rand_bits(2));
    return p[1] ? plane_e'(p) : PLANE_Y;
  endfunction

  // ------------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------------
  function automatic int table_bank(blk_size_e s, logic [1:0] rot, int lane);
    int k;
    k = int'(rot) * 4 + lane;
    case (s)
      SIZE_08: return T8[k];
      SIZE_16: return T16[k];
      default: return T32[k];
    endcase
  endfunction

  function automatic logic [1:0] rot_of(blk_size_e s, logic [3:0] x, logic [4:0] idx);
    case (s)
      SIZE_08: return x[2:1];
      SIZE_16: return {x[2], idx[1]};
      default: return idx[1:0];
    endcase
  endfunction

  // region, then row, then the lane that bank b serves
  function automatic int word_addr(plane_e p, blk_size_e s, logic [3:0] x, logic [3:0] y,
                                   logic [4:0] idx, int b);
    int region;
    int row;
    int col;
    if (p == PLANE_Y) begin
      region = 2 * int'(y[3]) + int'(x[3]);
    end else begin
      region = (p == PLANE_V) ? 5 : 4;
    end
    case (s)
      SIZE_08: row = 2 * int'(y[2:1]) + int'(idx[2]);
      SIZE_16: row = 4 * int'(y[2]) + int'(idx[3:2]);
      default: row = int'(idx[4:2]);
    endcase
    col = 0;
    for (int j = 0; j < NUM_BANKS; j++) begin
      if (table_bank(s, rot_of(s, x, idx), j) == b) begin
        col = j;
      end
    end
    return region * 32 + row * 4 + col;
  endfunction

  task automatic model_write(plane_e p, blk_size_e s, logic [3:0] x, logic [3:0] y,
                             logic [4:0] idx, logic [ROW_W-1:0] dat);
    int b;
    int a;
    for (int j = 0; j < NUM_BANKS; j++) begin
      b = table_bank(s, rot_of(s, x, idx), j);
      a = word_addr(p, s, x, y, idx, b);
      model_mem[b][a] = dat[(NUM_BANKS-1-j)*WORD_W +: WORD_W];
      model_set[b][a] = 1'b1;
    end
  endtask

  task automatic model_read(plane_e p, blk_size_e s, logic [3:0] x, logic [3:0] y,
                            logic [4:0] idx, output logic [ROW_W-1:0] dat,
                            output logic [3:0] mask);
    int b;
    int a;
    for (int j = 0; j < NUM_BANKS; j++) begin
      b = table_bank(s, rot_of(s, x, idx), j);
      a = word_addr(p, s, x, y, idx, b);
      dat[(NUM_BANKS-1-j)*WORD_W +: WORD_W] = model_mem[b][a];
      mask[j] = model_set[b][a];
    end
  endtask

  // ------------------------------------------------------------------------
  // checks and cycle driver
  // ------------------------------------------------------------------------
  task automatic check_eq(logic [63:0] got, logic [63:0] exp, string what);
    if (got !== exp) begin
      fail_cnt++;
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic timed_out(string what);
    $display("timeout while waiting for %s", what);
    $display("Checks failed");
    $fatal(1, "wait loop ran out of cycles");
  endtask

  task automatic drive_next();
    wr_valid <= n_wr_valid;
    wr_plane <= n_wr_plane;
    wr_size  <= n_wr_size;
    wr_x     <= n_wr_x;
    wr_y     <= n_wr_y;
    wr_idx   <= n_wr_idx;
    wr_dat   <= n_wr_dat;
    rd_valid <= n_rd_valid;
    rd_plane <= n_rd_plane;
    rd_size  <= n_rd_size;
    rd_x     <= n_rd_x;
    rd_y     <= n_rd_y;
    rd_idx   <= n_rd_idx;
  endtask

  task automatic tick();
    @(posedge clk);
    // what the DUT sampled at this edge
    wr_taken = wr_valid && !rd_valid;
    if (wr_taken) begin
      model_write(wr_plane, wr_size, wr_x, wr_y, wr_idx, wr_dat);
    end else if (wr_valid) begin
      // the writer keeps its request until it is taken
      held_cnt++;
      n_wr_valid = 1'b1;
      n_wr_plane = wr_plane;
      n_wr_size  = wr_size;
      n_wr_x     = wr_x;
      n_wr_y     = wr_y;
      n_wr_idx   = wr_idx;
      n_wr_dat   = wr_dat;
    end
    exp_valid = rd_valid;
    if (rd_valid) begin
      model_read(rd_plane, rd_size, rd_x, rd_y, rd_idx, exp_dat, exp_mask);
    end
    drive_next();
    @(negedge clk);
    check_eq(64'(wr_ready), 64'(!rd_valid), "wr_ready_o against rd_valid_i");
    check_eq(64'(out_valid), 64'(exp_valid), "rd_valid_o one cycle after the read");
    for (int j = 0; j < NUM_BANKS; j++) begin
      if (exp_valid && exp_mask[j]) begin
        check_eq(out_dat[(NUM_BANKS-1-j)*WORD_W +: WORD_W],
                 exp_dat[(NUM_BANKS-1-j)*WORD_W +: WORD_W],
                 $sformatf("rd_dat_o lane %0d", j));
      end
    end
  endtask

  task automatic set_read(plane_e p, blk_size_e s, logic [3:0] x, logic [3:0] y,
                          logic [4:0] idx);
    n_rd_valid = 1'b1;
    n_rd_plane = p;
    n_rd_size  = s;
    n_rd_x     = x;
    n_rd_y     = y;
    n_rd_idx   = idx;
  endtask

  task automatic write_row(plane_e p, blk_size_e s, logic [3:0] x, logic [3:0] y,
                           logic [4:0] idx, logic [ROW_W-1:0] dat);
    int waited;
    waited = 0;
    n_wr_valid = 1'b1;
    n_wr_plane = p;
    n_wr_size  = s;
    n_wr_x     = x;
    n_wr_y     = y;
    n_wr_idx   = idx;
    n_wr_dat   = dat;
    tick();
    n_wr_valid = 1'b0;
    tick();
    while (!wr_taken) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        timed_out("write acceptance");
      end
      n_wr_valid = 1'b0;
      tick();
    end
  endtask

  task automatic read_row(plane_e p, blk_size_e s, logic [3:0] x, logic [3:0] y,
                          logic [4:0] idx);
    set_read(p, s, x, y, idx);
    tick();
    n_rd_valid = 1'b0;
    tick();
  endtask

  // let a held write finish and the last read come back
  task automatic drain();
    int waited;
    waited = 0;
    n_wr_valid = 1'b0;
    n_rd_valid = 1'b0;
    tick();
    while (wr_valid) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        timed_out("pending write to drain");
      end
      n_wr_valid = 1'b0;
      tick();
    end
  endtask

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial begin
    logic [3:0]       cx [16];
    logic [3:0]       cy [16];
    logic [4:0]       ci [16];
    blk_size_e        cs [16];
    logic [2:0]       g;
    logic             x3;
    logic             y3;
    logic [ROW_W-1:0] pdat;
    logic [3:0]       pmask;

    lfsr_state = 32'd92512;
    fail_cnt   = 0;
    held_cnt   = 0;
    wr_taken   = 1'b0;
    exp_valid  = 1'b0;
    exp_dat    = '0;
    exp_mask   = '0;
    rstn       = 1'b0;
    n_wr_valid = 1'b0;
    n_wr_plane = PLANE_Y;
    n_wr_size  = SIZE_08;
    n_wr_x     = '0;
    n_wr_y     = '0;
    n_wr_idx   = '0;
    n_wr_dat   = '0;
    set_read(PLANE_Y, SIZE_08, 4'd0, 4'd0, 5'd0);
    n_rd_valid = 1'b0;
    drive_next();

    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    check_eq(64'(out_valid), 64'd0, "rd_valid_o after reset");
    check_eq(64'(wr_ready), 64'd1, "wr_ready_o after reset");

    // luma rows per size, read back at the same coordinates
    for (int sz = 1; sz <= 3; sz++) begin
      for (int k = 0; k < 16; k++) begin
        cx[k] = 4'(rand_bits(4));
        cy[k] = 4'(rand_bits(4));
        ci[k] = 5'(rand_bits(5));
        write_row(PLANE_Y, blk_size_e'(2'(sz)), cx[k], cy[k], ci[k], rand_row());
      end
      for (int k = 0; k < 16; k++) begin
        read_row(PLANE_Y, blk_size_e'(2'(sz)), cx[k], cy[k], ci[k]);
      end
    end

    // u and v at the same coordinates, then luma must be untouched
    for (int k = 0; k < 12; k++) begin
      cx[k] = 4'(rand_bits(4));
      cy[k] = 4'(rand_bits(4));
      ci[k] = 5'(rand_bits(5));
      cs[k] = rand_size();
      write_row(PLANE_U, cs[k], cx[k], cy[k], ci[k], rand_row());
      write_row(PLANE_V, cs[k], cx[k], cy[k], ci[k], rand_row());
    end
    for (int k = 0; k < 12; k++) begin
      read_row(PLANE_U, cs[k], cx[k], cy[k], ci[k]);
      read_row(PLANE_V, cs[k], cx[k], cy[k], ci[k]);
    end
    for (int k = 0; k < 16; k++) begin
      read_row(PLANE_Y, rand_size(), 4'(rand_bits(4)), 4'(rand_bits(4)), 5'(rand_bits(5)));
    end

    // mixed traffic, reads in about three cycles of four
    for (int c = 0; c < 300; c++) begin
      set_read(rand_plane(), rand_size(), 4'(rand_bits(4)), 4'(rand_bits(4)),
               5'(rand_bits(5)));
      n_rd_valid = (rand_bits(2) != 64'd0);
      n_wr_valid = 1'(rand_bits(1));
      n_wr_plane = rand_plane();
      n_wr_size  = rand_size();
      n_wr_x     = 4'(rand_bits(4));
      n_wr_y     = 4'(rand_bits(4));
      n_wr_idx   = 5'(rand_bits(5));
      n_wr_dat   = rand_row();
      tick();
    end
    drain();
    check_eq(64'(held_cnt > 0), 64'd1, "writes held back by reads");

    // back-to-back reads
    for (int k = 0; k < 16; k++) begin
      set_read(PLANE_Y, rand_size(), 4'(rand_bits(4)), 4'(rand_bits(4)), 5'(rand_bits(5)));
      tick();
    end
    drain();

    // four size 32 rows fill one row group, read it back at size 8
    g  = 3'(rand_bits(3));
    x3 = 1'(rand_bits(1));
    y3 = 1'(rand_bits(1));
    for (int r = 0; r < 4; r++) begin
      write_row(PLANE_Y, SIZE_32, {x3, 3'b000}, {y3, 3'b000}, {g, 2'(r)}, rand_row());
    end
    for (int r = 0; r < 4; r++) begin
      model_read(PLANE_Y, SIZE_08, {x3, 2'(r), 1'b0}, {y3, g[2:1], 1'b0},
                 {2'b00, g[0], 2'b00}, pdat, pmask);
      check_eq(64'(pmask), 64'hf, "size 8 lanes covered by size 32 rows");
      read_row(PLANE_Y, SIZE_08, {x3, 2'(r), 1'b0}, {y3, g[2:1], 1'b0}, {2'b00, g[0], 2'b00});
    end
    drain();

    if (fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
hw/fetch_buf_pkg.sv
hw/blk_addr_map.sv
hw/bank_ram.sv
hw/bank_array.sv
hw/fetch_buf_top.sv
bench/tb_fetch_buf.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the result from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module tb_fetch_buf -o sim_fetch_buf

status=0
./obj_dir/sim_fetch_buf > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
if ! grep -q "All checks passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
